//--- bench/prime_mover_trace.txt
// columns: wind speed Q16.16, rotor speed Q16.16, power Q32.16, torque Q32.16
// lines 0-9 back to back, 10-13 dropped by a reset, 14-27 with random gaps
00080000 00080000 00002A495B6D FFFFFAB6D493
000A0000 00100000 00005EDCCE66 FFFFFA12331A
000C0000 00010000 000000000000 000000000000
00060000 00040000 00000A94FD36 FFFFFD5AC0B3
00040000 00200000 00000136D874 FFFFFFF6493D
00050000 00080000 00000BDB99CC FFFFFE848CC7
00060000 00000000 000000000000 000000000000
00000000 00080000 000000000000 000000000000
00080000 00080000 00002A495B6D FFFFFAB6D493
000A0000 00100000 00005EDCCE66 FFFFFA12331A
00060000 00040000 00000A94FD36 FFFFFD5AC0B3
00050000 00080000 00000BDB99CC FFFFFE848CC7
00040000 00200000 00000136D874 FFFFFFF6493D
00080000 00080000 00002A495B6D FFFFFAB6D493
000A0000 00008000 000000000000 000000000000
000A0000 00100000 00005EDCCE66 FFFFFA12331A
00060000 00040000 00000A94FD36 FFFFFD5AC0B3
00000000 00080000 000000000000 000000000000
00050000 00080000 00000BDB99CC FFFFFE848CC7
00080000 00080000 00002A495B6D FFFFFAB6D493
00040000 00200000 00000136D874 FFFFFFF6493D
00060000 00000000 000000000000 000000000000
000C0000 00010000 000000000000 000000000000
00060000 00040000 00000A94FD36 FFFFFD5AC0B3
000A0000 00100000 00005EDCCE66 FFFFFA12331A
00050000 00080000 00000BDB99CC FFFFFE848CC7
00080000 00080000 00002A495B6D FFFFFAB6D493
00040000 00200000 00000136D874 FFFFFFF6493D

//--- bench/tb_prime_mover.sv
module tb_prime_mover
  import turbine_pkg::*;
;

  localparam int TRACE_LEN = 28;
  // one drain before the mid-stream reset and one at the end
  localparam int CYCLE_LIMIT = TRACE_LEN * 4 + 2 * PIPE_LATENCY + 50;

  logic   clk_sim;
  logic   reset;
  logic   in_valid;
  speed_t wind_speed;
  speed_t rotor_speed;
  logic   out_valid;
  power_t mech_power;
  power_t mech_torque;

  logic [47:0] trace_mem [0:TRACE_LEN*4-1];
  int          due_q[$];
  power_t      power_q[$];
  power_t      torque_q[$];
  int          cycle;
  int          value_errors;
  int          protocol_errors;

  prime_mover i_dut (
    .clk_sim    (clk_sim),
    .reset      (reset),
    .in_valid   (in_valid),
    .wind_speed (wind_speed),
    .rotor_speed(rotor_speed),
    .out_valid  (out_valid),
    .mech_power (mech_power),
    .mech_torque(mech_torque)
  );

  always #2 clk_sim = ~clk_sim;

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] expected);
    if (got !== expected) begin
      value_errors++;
      $display("Fail at time %0t: %s got %h expected %h", $time, what, got, expected);
    end
  endtask

  task automatic send_sample(input int line);
    @(negedge clk_sim);
    in_valid = 1'b1;
    wind_speed = speed_t'(trace_mem[4*line]);
    rotor_speed = speed_t'(trace_mem[4*line+1]);
    due_q.push_back(cycle + PIPE_LATENCY);
    power_q.push_back(power_t'(trace_mem[4*line+2]));
    torque_q.push_back(power_t'(trace_mem[4*line+3]));
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(negedge clk_sim);
      in_valid = 1'b0;
    end
  endtask

  task automatic wait_drained();
    while (due_q.size() != 0) begin
      @(negedge clk_sim);
    end
  endtask

  // cycle count and run limit
  always @(posedge clk_sim) begin
    cycle <= cycle + 1;
    if (cycle >= CYCLE_LIMIT) begin
      $display("timeout: results still outstanding after %0d cycles", CYCLE_LIMIT);
      $display("** FAIL **");
      $finish;
    end
  end

  // outputs are read a time unit after the falling edge
  always @(negedge clk_sim) begin : monitor
    #1;
    if (reset) begin
      if (out_valid !== 1'b0) begin
        protocol_errors++;
        $display("out_valid was not low during reset at time %0t", $time);
      end
      // samples in flight are lost
      due_q.delete();
      power_q.delete();
      torque_q.delete();
    end else if (out_valid) begin
      if (due_q.size() == 0) begin
        protocol_errors++;
        $display("out_valid was raised at time %0t with no sample in flight", $time);
      end else begin
        check_value("out_valid cycle", 64'(cycle), 64'(due_q[0]));
        check_value("mech_power", 64'(mech_power), 64'(power_q[0]));
        check_value("mech_torque", 64'(mech_torque), 64'(torque_q[0]));
        void'(due_q.pop_front());
        void'(power_q.pop_front());
        void'(torque_q.pop_front());
      end
    end else if (due_q.size() != 0 && cycle > due_q[0]) begin
      protocol_errors++;
      $display("result due at cycle %0d never appeared (time %0t)", due_q[0], $time);
      void'(due_q.pop_front());
      void'(power_q.pop_front());
      void'(torque_q.pop_front());
    end
  end

  initial begin
    clk_sim = 1'b0;
    reset = 1'b1;
    in_valid = 1'b0;
    wind_speed = '0;
    rotor_speed = '0;
    cycle = 0;
    value_errors = 0;
    protocol_errors = 0;
    void'($urandom(54));
    $readmemh("bench/prime_mover_trace.txt", trace_mem);

    repeat (2) @(posedge clk_sim);
    @(negedge clk_sim);
    reset = 1'b0;

    // back to back
    for (int i = 0; i < 10; i++) begin
      send_sample(i);
    end
    idle_cycles(1);
    wait_drained();

    // these never come out
    for (int i = 10; i < 14; i++) begin
      send_sample(i);
      idle_cycles($urandom % 4);
    end
    idle_cycles(1);
    @(negedge clk_sim);
    reset = 1'b1;
    repeat (2) @(negedge clk_sim);
    reset = 1'b0;
    idle_cycles(10);

    // random gaps
    for (int i = 14; i < TRACE_LEN; i++) begin
      send_sample(i);
      idle_cycles($urandom % 4);
    end
    idle_cycles(1);
    wait_drained();
    idle_cycles(5);

    $display("errors: %0d value, %0d protocol", value_errors, protocol_errors);
    if (value_errors == 0 && protocol_errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

//--- prime_mover.f
verilog/turbine_pkg.sv
verilog/pipelined_divider.sv
verilog/tip_speed_stage.sv
verilog/cp_stage.sv
verilog/power_stage.sv
verilog/torque_stage.sv
verilog/prime_mover.sv
bench/tb_prime_mover.sv

//--- run_sim.sh
#!/bin/sh
# build and run the prime mover testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f prime_mover.f \
  --top-module tb_prime_mover --Mdir obj_dir -o sim_prime_mover
./obj_dir/sim_prime_mover > sim.log
cat sim.log
grep -q '^\*\* PASS \*\*$' sim.log
echo "simulation passed"

//--- verilog/cp_stage.sv
module cp_stage
  import turbine_pkg::*;
(
  input  logic   clk_sim,
  input  logic   reset,
  input  logic   tip_valid,
  input  speed_t tip_ratio,
  input  speed_t tip_wind,
  input  speed_t tip_rotor,
  output logic   cp_valid,
  output speed_t cp_value,
  output speed_t cp_wind,
  output speed_t cp_rotor
);

  // cp at zero pitch, one entry per quarter of tip speed ratio
  speed_t cp_rom [0:CP_ENTRIES-1];

  cp_index_t                idx;
  cp_index_t                idx_next;
  logic                     rd_valid;
  speed_t                   lo_q;
  speed_t                   hi_q;
  logic [CP_STEP_SHIFT-1:0] frac_q;
  speed_t                   wind_q;
  speed_t                   rotor_q;
  logic signed [32:0]       span;
  product_t                 span_prod;
  product_t                 step;

  initial begin
    $readmemh("verilog/cp_table.hex", cp_rom);
  end

  // ratio never exceeds LAMBDA_MAX, so the index stays within 0 to 64
  assign idx = tip_ratio[CP_STEP_SHIFT +: $bits(cp_index_t)];
  // the last entry has no right neighbour
  assign idx_next = (idx == cp_index_t'(CP_ENTRIES - 1)) ? idx : idx + 1'b1;

  always_ff @(posedge clk_sim) begin
    if (reset) begin
      rd_valid <= 1'b0;
      cp_valid <= 1'b0;
    end else begin
      rd_valid <= tip_valid;
      cp_valid <= rd_valid;
    end
  end

  // first cycle, fetch both neighbours
  always_ff @(posedge clk_sim) begin
    lo_q <= cp_rom[idx];
    hi_q <= cp_rom[idx_next];
    frac_q <= tip_ratio[CP_STEP_SHIFT-1:0];
    wind_q <= tip_wind;
    rotor_q <= tip_rotor;
  end

  always_comb begin
    span = hi_q - lo_q;
    span_prod = span * $signed({1'b0, frac_q});
    step = shift_toward_zero(span_prod, CP_STEP_SHIFT);
  end

  // second cycle, linear interpolation
  always_ff @(posedge clk_sim) begin
    cp_value <= lo_q + speed_t'(step);
    cp_wind <= wind_q;
    cp_rotor <= rotor_q;
  end

  // a table entry above Betz would be a bad data file
  betz_bound: assert property (@(posedge clk_sim) disable iff (reset)
    cp_valid |-> cp_value < CP_BETZ_LIMIT);

endmodule

//--- verilog/cp_table.hex
// cp at zero pitch in Q16.16, entry i is tip speed ratio i/4, from 0 to 16
FFFFF800
FFFFF800
FFFFFC00
FFFFFC00
00000000
00000400
00000800
00000C00
00001000
00001800
00001C00
00002400
00002C00
00003000
00003800
00004000
00004800
00004C00
00005400
00005800
00006000
00006400
00006800
00006C00
00007000
00007400
00007400
00007800
00007800
00007800
00007C00
00007C00
00007C00
00007C00
00007C00
00007800
00007800
00007800
00007400
00007400
00007000
00007000
00006C00
00006800
00006800
00006400
00006000
00005C00
00005800
00005400
00005000
00004C00
00004800
00004400
00004000
00003C00
00003800
00003400
00003000
00002C00
00002800
00002400
00002000
00001C00
00001800

//--- verilog/pipelined_divider.sv
module pipelined_divider
  import turbine_pkg::*;
#(
  parameter int DIVIDEND_W = 64,
  parameter int DIVISOR_W = 32
) (
  input  logic                  clk_sim,
  input  logic                  reset,
  input  logic                  valid,
  input  logic [DIVIDEND_W-1:0] dividend,
  input  logic [DIVISOR_W-1:0]  divisor,
  output logic [DIVIDEND_W-1:0] quotient,
  output logic                  done
);

  // quotient bits resolved per register stage, padded up to a whole stage
  localparam int STEP = (DIVIDEND_W + DIV_LATENCY - 1) / DIV_LATENCY;
  localparam int WORK_W = STEP * DIV_LATENCY;

  // dividend bits shift out the top while quotient bits shift in below
  logic [WORK_W-1:0]    num_q   [1:DIV_LATENCY];
  logic                 valid_q [1:DIV_LATENCY];
  logic [DIVISOR_W-1:0] rem_q   [1:DIV_LATENCY-1];
  logic [DIVISOR_W-1:0] den_q   [1:DIV_LATENCY-1];

  for (genvar g = 0; g < DIV_LATENCY; g++) begin : g_stage
    logic [DIVISOR_W-1:0] rem_in;
    logic [WORK_W-1:0]    num_in;
    logic [DIVISOR_W-1:0] den_in;
    logic                 valid_in;
    logic [DIVISOR_W-1:0] rem_next;
    logic [WORK_W-1:0]    num_next;
    logic [DIVISOR_W:0]   trial;
    logic [DIVISOR_W:0]   diff;

    if (g == 0) begin : g_head
      assign rem_in = '0;
      assign num_in = WORK_W'(dividend);
      assign den_in = divisor;
      assign valid_in = valid;
    end else begin : g_link
      assign rem_in = rem_q[g];
      assign num_in = num_q[g];
      assign den_in = den_q[g];
      assign valid_in = valid_q[g];
    end

    // restoring steps, subtract only when the trial remainder allows it
    always_comb begin
      rem_next = rem_in;
      num_next = num_in;
      trial = '0;
      diff = '0;
      for (int b = 0; b < STEP; b++) begin
        trial = {rem_next, num_next[WORK_W-1]};
        diff = trial - {1'b0, den_in};
        num_next = num_next << 1;
        if (trial >= {1'b0, den_in}) begin
          rem_next = diff[DIVISOR_W-1:0];
          num_next[0] = 1'b1;
        end else begin
          rem_next = trial[DIVISOR_W-1:0];
        end
      end
    end

    always_ff @(posedge clk_sim) begin
      if (reset) begin
        valid_q[g+1] <= 1'b0;
      end else begin
        valid_q[g+1] <= valid_in;
      end
    end

    always_ff @(posedge clk_sim) begin
      num_q[g+1] <= num_next;
    end

    // last stage only needs the quotient
    if (g < DIV_LATENCY - 1) begin : g_carry
      always_ff @(posedge clk_sim) begin
        rem_q[g+1] <= rem_next;
        den_q[g+1] <= den_in;
      end
    end
  end

  assign quotient = num_q[DIV_LATENCY][DIVIDEND_W-1:0];
  assign done = valid_q[DIV_LATENCY];

  // callers swap a zero divisor for one before it gets here
  divisor_nonzero: assert property (@(posedge clk_sim) disable iff (reset)
    valid |-> divisor != '0);

endmodule

//--- verilog/power_stage.sv
module power_stage
  import turbine_pkg::*;
(
  input  logic   clk_sim,
  input  logic   reset,
  input  logic   cp_valid,
  input  speed_t cp_value,
  input  speed_t cp_wind,
  input  speed_t cp_rotor,
  output logic   pow_valid,
  output power_t pow_value,
  output speed_t pow_rotor
);

  logic     sq_valid;
  logic     cube_valid;
  logic     raw_valid;
  power_t   sq_q;
  power_t   cube_q;
  power_t   raw_q;
  speed_t   wind_d1;
  speed_t   cp_d1;
  speed_t   cp_d2;
  speed_t   rotor_d1;
  speed_t   rotor_d2;
  speed_t   rotor_d3;
  product_t sq_full;
  product_t wind_cube;
  product_t cube_full;
  product_t raw_full;

  always_comb begin
    sq_full = shift_toward_zero(product_t'(cp_wind) * product_t'(cp_wind), Q_FRAC);
    wind_cube = shift_toward_zero(product_t'(sq_q) * product_t'(wind_d1), Q_FRAC);
    cube_full = shift_toward_zero(wind_cube * product_t'(POWER_CONST), Q_FRAC);
    raw_full = shift_toward_zero(product_t'(cube_q) * product_t'(cp_d2), Q_FRAC);
  end

  always_ff @(posedge clk_sim) begin
    if (reset) begin
      sq_valid <= 1'b0;
      cube_valid <= 1'b0;
      raw_valid <= 1'b0;
      pow_valid <= 1'b0;
    end else begin
      sq_valid <= cp_valid;
      cube_valid <= sq_valid;
      raw_valid <= cube_valid;
      pow_valid <= raw_valid;
    end
  end

  always_ff @(posedge clk_sim) begin
    // v^2
    sq_q <= power_t'(sq_full);
    wind_d1 <= cp_wind;
    cp_d1 <= cp_value;
    rotor_d1 <= cp_rotor;
    // 0.5 * rho * A * v^3
    cube_q <= power_t'(cube_full);
    cp_d2 <= cp_d1;
    rotor_d2 <= rotor_d1;
    // times cp
    raw_q <= power_t'(raw_full);
    rotor_d3 <= rotor_d2;
    // negative cp or reverse wind delivers no power
    pow_value <= raw_q[$bits(power_t)-1] ? '0 : raw_q;
    pow_rotor <= rotor_d3;
  end

  pow_nonneg: assert property (@(posedge clk_sim) disable iff (reset)
    pow_valid |-> !pow_value[$bits(power_t)-1]);

endmodule

//--- verilog/prime_mover.sv
module prime_mover
  import turbine_pkg::*;
(
  input  logic   clk_sim,
  input  logic   reset,
  input  logic   in_valid,
  input  speed_t wind_speed,
  input  speed_t rotor_speed,
  output logic   out_valid,
  output power_t mech_power,
  output power_t mech_torque
);

  logic   tip_valid;
  speed_t tip_ratio;
  speed_t tip_wind;
  speed_t tip_rotor;
  logic   cp_valid;
  speed_t cp_value;
  speed_t cp_wind;
  speed_t cp_rotor;
  logic   pow_valid;
  power_t pow_value;
  speed_t pow_rotor;

  tip_speed_stage i_tip (
    .clk_sim    (clk_sim),
    .reset      (reset),
    .in_valid   (in_valid),
    .wind_speed (wind_speed),
    .rotor_speed(rotor_speed),
    .tip_valid  (tip_valid),
    .tip_ratio  (tip_ratio),
    .tip_wind   (tip_wind),
    .tip_rotor  (tip_rotor)
  );

  cp_stage i_cp (
    .clk_sim  (clk_sim),
    .reset    (reset),
    .tip_valid(tip_valid),
    .tip_ratio(tip_ratio),
    .tip_wind (tip_wind),
    .tip_rotor(tip_rotor),
    .cp_valid (cp_valid),
    .cp_value (cp_value),
    .cp_wind  (cp_wind),
    .cp_rotor (cp_rotor)
  );

  power_stage i_power (
    .clk_sim  (clk_sim),
    .reset    (reset),
    .cp_valid (cp_valid),
    .cp_value (cp_value),
    .cp_wind  (cp_wind),
    .cp_rotor (cp_rotor),
    .pow_valid(pow_valid),
    .pow_value(pow_value),
    .pow_rotor(pow_rotor)
  );

  torque_stage i_torque (
    .clk_sim    (clk_sim),
    .reset      (reset),
    .pow_valid  (pow_valid),
    .pow_value  (pow_value),
    .pow_rotor  (pow_rotor),
    .out_valid  (out_valid),
    .mech_power (mech_power),
    .mech_torque(mech_torque)
  );

endmodule

//--- verilog/tip_speed_stage.sv
module tip_speed_stage
  import turbine_pkg::*;
(
  input  logic   clk_sim,
  input  logic   reset,
  input  logic   in_valid,
  input  speed_t wind_speed,
  input  speed_t rotor_speed,
  output logic   tip_valid,
  output speed_t tip_ratio,
  output speed_t tip_wind,
  output speed_t tip_rotor
);

  logic signed [63:0] radius_prod;
  logic               mul_valid;
  logic [63:0]        prod_mag_q;
  logic [31:0]        wind_mag_q;
  logic               zero_wind_q;
  logic               neg_q;
  speed_t             wind_q;
  speed_t             rotor_q;
  logic [63:0]        ratio_raw;
  logic               zero_dly  [0:DIV_LATENCY-1];
  logic               neg_dly   [0:DIV_LATENCY-1];
  speed_t             wind_dly  [0:DIV_LATENCY-1];
  speed_t             rotor_dly [0:DIV_LATENCY-1];

  // Q32.32 product so the quotient by a Q16.16 wind speed lands in Q16.16
  assign radius_prod = ROTOR_RADIUS * rotor_speed;

  always_ff @(posedge clk_sim) begin
    if (reset) begin
      mul_valid <= 1'b0;
    end else begin
      mul_valid <= in_valid;
    end
  end

  always_ff @(posedge clk_sim) begin
    prod_mag_q <= radius_prod[63] ? -radius_prod : radius_prod;
    zero_wind_q <= (wind_speed == '0);
    if (wind_speed == '0) begin
      wind_mag_q <= 32'd1;
    end else begin
      wind_mag_q <= wind_speed[31] ? -wind_speed : wind_speed;
    end
    neg_q <= radius_prod[63] ^ wind_speed[31];
    wind_q <= wind_speed;
    rotor_q <= rotor_speed;
  end

  pipelined_divider #(
    .DIVIDEND_W(64),
    .DIVISOR_W (32)
  ) i_divider (
    .clk_sim (clk_sim),
    .reset   (reset),
    .valid   (mul_valid),
    .dividend(prod_mag_q),
    .divisor (wind_mag_q),
    .quotient(ratio_raw),
    .done    (tip_valid)
  );

  // side values ride alongside the divider
  always_ff @(posedge clk_sim) begin
    zero_dly[0] <= zero_wind_q;
    neg_dly[0] <= neg_q;
    wind_dly[0] <= wind_q;
    rotor_dly[0] <= rotor_q;
    for (int i = 1; i < DIV_LATENCY; i++) begin
      zero_dly[i] <= zero_dly[i-1];
      neg_dly[i] <= neg_dly[i-1];
      wind_dly[i] <= wind_dly[i-1];
      rotor_dly[i] <= rotor_dly[i-1];
    end
  end

  always_comb begin
    if (zero_dly[DIV_LATENCY-1]) begin
      tip_ratio = LAMBDA_MAX;
    end else if (neg_dly[DIV_LATENCY-1]) begin
      tip_ratio = '0;
    end else if (ratio_raw > 64'(LAMBDA_MAX)) begin
      tip_ratio = LAMBDA_MAX;
    end else begin
      tip_ratio = ratio_raw[31:0];
    end
  end

  assign tip_wind = wind_dly[DIV_LATENCY-1];
  assign tip_rotor = rotor_dly[DIV_LATENCY-1];

endmodule

//--- verilog/torque_stage.sv
module torque_stage
  import turbine_pkg::*;
(
  input  logic   clk_sim,
  input  logic   reset,
  input  logic   pow_valid,
  input  power_t pow_value,
  input  speed_t pow_rotor,
  output logic   out_valid,
  output power_t mech_power,
  output power_t mech_torque
);

  logic        zero_rotor;
  logic [31:0] rotor_mag;
  logic [63:0] dividend;
  logic [63:0] quot;
  logic        div_done;
  logic        zero_dly  [0:DIV_LATENCY-1];
  logic        neg_dly   [0:DIV_LATENCY-1];
  power_t      power_dly [0:DIV_LATENCY-1];

  assign zero_rotor = (pow_rotor == '0);
  assign rotor_mag = zero_rotor ? 32'd1 : (pow_rotor[31] ? -pow_rotor : pow_rotor);
  // Q32.16 power scaled up so the quotient stays in Q32.16
  assign dividend = {pow_value, {Q_FRAC{1'b0}}};

  pipelined_divider #(
    .DIVIDEND_W(64),
    .DIVISOR_W (32)
  ) i_divider (
    .clk_sim (clk_sim),
    .reset   (reset),
    .valid   (pow_valid),
    .dividend(dividend),
    .divisor (rotor_mag),
    .quotient(quot),
    .done    (div_done)
  );

  always_ff @(posedge clk_sim) begin
    zero_dly[0] <= zero_rotor;
    neg_dly[0] <= pow_rotor[31];
    power_dly[0] <= pow_value;
    for (int i = 1; i < DIV_LATENCY; i++) begin
      zero_dly[i] <= zero_dly[i-1];
      neg_dly[i] <= neg_dly[i-1];
      power_dly[i] <= power_dly[i-1];
    end
  end

  always_ff @(posedge clk_sim) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= div_done;
    end
  end

  // motor convention, T = -P / w
  always_ff @(posedge clk_sim) begin
    mech_power <= power_dly[DIV_LATENCY-1];
    if (zero_dly[DIV_LATENCY-1]) begin
      mech_torque <= '0;
    end else if (neg_dly[DIV_LATENCY-1]) begin
      mech_torque <= power_t'(quot);
    end else begin
      mech_torque <= -power_t'(quot);
    end
  end

endmodule

//--- verilog/turbine_pkg.sv
package turbine_pkg;

  // signed Q16.16 for wind speed, rotor speed, tip speed ratio and cp
  typedef logic signed [31:0] speed_t;
  // signed Q32.16 for mechanical power and torque
  typedef logic signed [47:0] power_t;
  // full width of any intermediate product
  typedef logic signed [95:0] product_t;
  // power coefficient table index, 0 to 64
  typedef logic [6:0] cp_index_t;

  // fractional bits of the Q16.16 and Q32.16 formats
  localparam int Q_FRAC = 16;

  // rotor radius, 5.53 m
  localparam speed_t ROTOR_RADIUS = 32'h0005_87AE;
  // 0.5 * air density 1.08 * swept area 95.94
  localparam speed_t POWER_CONST = 32'h0033_CEBE;
  // tip speed ratio ceiling, 16.0
  localparam speed_t LAMBDA_MAX = 32'h0010_0000;
  // Betz limit, 0.593
  localparam speed_t CP_BETZ_LIMIT = 32'h0000_97CE;

  // cp table covers ratios 0 to 16 in quarter steps
  localparam int CP_ENTRIES = 65;
  localparam int CP_STEP_SHIFT = 14;

  // stage latencies in clock cycles
  localparam int DIV_LATENCY = 32;
  localparam int TIP_LATENCY = DIV_LATENCY + 1;
  localparam int CP_LATENCY = 2;
  localparam int POWER_LATENCY = 4;
  localparam int TORQUE_LATENCY = DIV_LATENCY + 1;
  localparam int PIPE_LATENCY = TIP_LATENCY + CP_LATENCY + POWER_LATENCY + TORQUE_LATENCY;

  // arithmetic right shift that rounds toward zero instead of down
  function automatic product_t shift_toward_zero(input product_t value,
                                                 input int unsigned amount);
    logic [95:0] magnitude;
    logic [95:0] scaled;
    magnitude = value[95] ? -value : value;
    scaled = magnitude >> amount;
    return value[95] ? -$signed(scaled) : $signed(scaled);
  endfunction

endpackage
